// ==== sim.f ====
+incdir+hdl
hdl/lsq_pkg.sv
hdl/load_decode.sv
hdl/load_agu.sv
hdl/load_addr_queue.sv
hdl/load_issue_retire.sv
hdl/load_unit.sv
test/clk_gen.sv
test/load_unit_tb.sv

// ==== test/load_unit_tb.sv ====
`timescale 1ns/100ps
`include "lsq_defines.svh"

module load_unit_tb
	import lsq_pkg::*;
();

localparam int N_LOADS = 47;
localparam int LIMIT   = 200 * N_LOADS + 1000;

logic               i_clk;
logic               i_rst_n;
logic               i_insn_val;
insn_t              i_insn;
addr_t              i_base;
logic               i_mem_ready;
logic               i_resp_val;
mem_resp_t          i_resp;
logic               i_fwd_val;
lq_idx_t            i_fwd_idx;
logic               o_stall;
logic               o_req_val;
mem_req_t           o_req;
logic               o_wb_val;
wb_t                o_wb;
logic [`DROP_W-1:0] o_drop_cnt;

wb_t     exp_q[$];
lq_idx_t pend_idx[$];
int      pend_due[$];
addr_t   exp_addr [0:`LQ_DEPTH-1];
logic    miss_next [0:`LQ_DEPTH-1];
int      req_cnt [0:`LQ_DEPTH-1];
lq_idx_t tb_tail;
int      cyc;
int      resp_extra;
int      n_req;
int      n_wb;
int      n_err;
int      n_chk;
int      n_test;
int      test_err0;
logic    ready_rand;
logic    ready_level;

clk_gen u_clk (
	.o_clk   (i_clk),
	.o_rst_n (i_rst_n)
);

load_unit UUT (
	.i_clk      (i_clk),
	.i_rst_n    (i_rst_n),
	.i_insn_val (i_insn_val),
	.i_insn     (i_insn),
	.i_base     (i_base),
	.i_mem_ready(i_mem_ready),
	.i_resp_val (i_resp_val),
	.i_resp     (i_resp),
	.i_fwd_val  (i_fwd_val),
	.i_fwd_idx  (i_fwd_idx),
	.o_stall    (o_stall),
	.o_req_val  (o_req_val),
	.o_req      (o_req),
	.o_wb_val   (o_wb_val),
	.o_wb       (o_wb),
	.o_drop_cnt (o_drop_cnt)
);

// expected writeback of one dispatched instruction, 0 when none is due
function automatic logic ref_wb(input insn_t insn, input addr_t base, output wb_t wb);
	wb.rd   = insn.rd;
	wb.tag  = insn.tag;
	wb.addr = base + addr_t'($signed(insn.imm));
	return (insn.opc == `OPC_LOAD) && (insn.rd != 0);
endfunction

function automatic insn_t make_insn(input int opc, input int rd, input int tag, input int imm);
	insn_t r;
	r.opc = opc[`OPC_W-1:0];
	r.rd  = rd[`REG_W-1:0];
	r.tag = tag[`TAG_W-1:0];
	r.imm = imm[`IMM_W-1:0];
	return r;
endfunction

task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
	n_chk++;
	if (got !== exp) begin
		n_err++;
		$display("FAIL %s: got %h, expected %h", name, got, exp);
	end
endtask

task automatic report_error(input string what);
	n_err++;
	$display("error: %s", what);
endtask

task automatic start_test();
	n_test++;
	test_err0 = n_err;
	for (int k = 0; k < `LQ_DEPTH; k++)
		req_cnt[k] = 0;
endtask

task automatic end_test(input string name);
	if (n_err == test_err0)
		$display("test %0d %s: pass", n_test, name);
	else
		$display("test %0d %s: %0d errors", n_test, name, n_err - test_err0);
endtask

// waits for room, one dispatch every second cycle keeps o_stall current
task automatic dispatch(input insn_t insn, input addr_t base, input logic miss);
	wb_t e;
	logic wb_due;
	@(negedge i_clk);
	while (o_stall)
		@(negedge i_clk);
	@(posedge i_clk);
	i_insn_val <= 1'b1;
	i_insn     <= insn;
	i_base     <= base;
	wb_due = ref_wb(insn, base, e);
	if (insn.opc == `OPC_LOAD) begin
		exp_addr[tb_tail]  = e.addr;
		miss_next[tb_tail] = miss;
		tb_tail            = tb_tail + 1'b1;
	end
	if (wb_due)
		exp_q.push_back(e);
	@(posedge i_clk);
	i_insn_val <= 1'b0;
endtask

task automatic drain();
	int k;
	k = 0;
	while ((exp_q.size() != 0 || pend_idx.size() != 0) && k < 3000) begin
		@(negedge i_clk);
		k++;
	end
	if (k >= 3000)
		report_error("loads still outstanding after 3000 cycles");
	repeat (4) @(negedge i_clk);
endtask

// request monitor, feeds the memory model
always @(negedge i_clk) begin
	cyc++;
	if (o_req_val) begin
		n_req++;
		req_cnt[o_req.idx]++;
		check("o_req.addr", o_req.addr, exp_addr[o_req.idx]);
		pend_idx.push_back(o_req.idx);
		pend_due.push_back(cyc + resp_extra + 1 + int'($urandom % 6));
	end
end

// memory model, one answer per cycle
always @(posedge i_clk) begin : respond
	int sel;
	sel = -1;
	for (int k = pend_idx.size() - 1; k >= 0; k--)
		if (pend_due[k] <= cyc)
			sel = k;
	i_resp_val <= 1'b0;
	if (sel >= 0) begin
		i_resp_val     <= 1'b1;
		i_resp.idx     <= pend_idx[sel];
		i_resp.miss    <= miss_next[pend_idx[sel]];
		miss_next[pend_idx[sel]] = 1'b0;
		pend_idx.delete(sel);
		pend_due.delete(sel);
	end
end

always @(posedge i_clk)
	i_mem_ready <= ready_rand ? ($urandom % 4 != 0) : ready_level;

always @(negedge i_clk) begin : compare_wb
	wb_t e;
	if (o_wb_val) begin
		n_wb++;
		if (exp_q.size() == 0) begin
			report_error("writeback seen with no load waiting for one");
		end else begin
			e = exp_q.pop_front();
			check("o_wb.rd", o_wb.rd, e.rd);
			check("o_wb.tag", o_wb.tag, e.tag);
			check("o_wb.addr", o_wb.addr, e.addr);
		end
	end
end

initial begin
	repeat (LIMIT) @(posedge i_clk);
	$display("timeout: run did not end within %0d cycles", LIMIT);
	$display("Something failed");
	$finish;
end

initial begin : main
	int seed;
	int req0;
	int wb0;
	int misses;
	logic m;
	logic [`DROP_W-1:0] drop0;
	lq_idx_t idx;
	logic stall_before;
	int k;

	seed = $urandom(32'hfce1_3230);
	i_insn_val = 1'b0;
	i_insn     = '0;
	i_base     = '0;
	i_mem_ready = 1'b0;
	i_resp_val = 1'b0;
	i_resp     = '0;
	i_fwd_val  = 1'b0;
	i_fwd_idx  = '0;
	ready_rand = 1'b0;
	ready_level = 1'b1;
	resp_extra = 0;
	tb_tail    = '0;
	cyc = 0;
	n_req = 0;
	n_wb = 0;
	n_err = 0;
	n_chk = 0;
	n_test = 0;
	for (int i = 0; i < `LQ_DEPTH; i++) begin
		exp_addr[i]  = '0;
		miss_next[i] = 1'b0;
	end

	// random loads with random memory readiness and some misses
	start_test();
	wait (i_rst_n === 1'b1);
	@(negedge i_clk);
	check("o_req_val", o_req_val, 0);
	check("o_wb_val", o_wb_val, 0);
	check("o_stall", o_stall, 0);
	ready_rand = 1'b1;
	req0 = n_req;
	misses = 0;
	for (int i = 0; i < 24; i++) begin
		m = ($urandom % 4) == 0;
		misses += m;
		dispatch(make_insn(`OPC_LOAD, 1 + $urandom % 31, $urandom, $urandom), $urandom, m);
	end
	drain();
	ready_rand = 1'b0;
	check("request count", n_req - req0, 24 + misses);
	end_test("random loads");

	// rd 0 loads and non-load opcodes
	start_test();
	drop0 = o_drop_cnt;
	wb0 = n_wb;
	dispatch(make_insn(`OPC_LOAD, 0, 1, 12'h010), 32'h0000_1000, 1'b0);
	dispatch(make_insn(4'h5, 3, 2, 12'h020), 32'h0000_2000, 1'b0);
	dispatch(make_insn(`OPC_LOAD, 7, 3, 12'hffc), 32'h0000_3000, 1'b0);
	dispatch(make_insn(`OPC_LOAD, 0, 4, 12'h004), 32'h0000_4000, 1'b0);
	dispatch(make_insn(4'h0, 8, 5, 12'h000), 32'h0000_5000, 1'b0);
	dispatch(make_insn(`OPC_LOAD, 9, 6, 12'h800), 32'h0001_0000, 1'b0);
	dispatch(make_insn(4'hf, 1, 7, 12'h001), 32'h0000_6000, 1'b0);
	dispatch(make_insn(`OPC_LOAD, 12, 8, 12'h7ff), 32'hffff_f000, 1'b0);
	drain();
	check("o_drop_cnt increase", o_drop_cnt - drop0, 3);
	check("writeback count", n_wb - wb0, 3);
	end_test("rd 0 and non-load");

	// miss then replay
	start_test();
	wb0 = n_wb;
	idx = tb_tail;
	dispatch(make_insn(`OPC_LOAD, 21, 17, 12'h123), 32'h8000_0040, 1'b1);
	drain();
	check("requests for missed load", req_cnt[idx], 2);
	check("writeback count", n_wb - wb0, 1);
	end_test("miss replay");

	// fill the queue with memory blocked
	start_test();
	ready_level = 1'b0;
	req0 = n_req;
	for (int i = 0; i < `LQ_DEPTH; i++)
		dispatch(make_insn(`OPC_LOAD, 1 + i, i, 16 * i), 32'h0004_0000 + 32'(i * 64), 1'b0);
	repeat (4) @(negedge i_clk);
	check("o_stall when full", o_stall, 1);
	check("requests while not ready", n_req - req0, 0);
	ready_level = 1'b1;
	k = 0;
	@(negedge i_clk);
	stall_before = o_stall;
	while (!o_wb_val && k < 200) begin
		stall_before = o_stall;
		@(negedge i_clk);
		k++;
	end
	if (k >= 200)
		report_error("no writeback after memory became ready");
	check("o_stall before first retire", stall_before, 1);
	check("o_stall at first writeback", o_stall, 0);
	drain();
	check("requests after ready", n_req - req0, `LQ_DEPTH);
	end_test("full queue");

	// forward hint while the first request waits
	start_test();
	wb0 = n_wb;
	resp_extra = 8;
	idx = tb_tail;
	dispatch(make_insn(`OPC_LOAD, 30, 29, 12'h0a0), 32'h0010_0000, 1'b0);
	k = 0;
	while (req_cnt[idx] == 0 && k < 100) begin
		@(negedge i_clk);
		k++;
	end
	if (k >= 100)
		report_error("load issued no request");
	@(posedge i_clk);
	i_fwd_val <= 1'b1;
	i_fwd_idx <= idx;
	@(posedge i_clk);
	i_fwd_val <= 1'b0;
	drain();
	resp_extra = 0;
	check("requests for hinted load", req_cnt[idx], 2);
	check("writeback count", n_wb - wb0, 1);
	end_test("forward hint");

	$display("tests %0d, checks %0d, errors %0d", n_test, n_chk, n_err);
	if (n_err == 0)
		$display("Everything OK");
	else
		$display("Something failed");
	$finish;
end

endmodule

// ==== test/clk_gen.sv ====
`timescale 1ns/100ps

module clk_gen #(
	parameter real PERIOD     = 4.0,
	parameter int  RST_CYCLES = 5
) (
	output logic o_clk,
	output logic o_rst_n
);

initial begin
	o_clk = 1'b0;
	forever #(PERIOD / 2.0) o_clk = ~o_clk;
end

// release on a clock edge
initial begin
	o_rst_n = 1'b0;
	repeat (RST_CYCLES) @(posedge o_clk);
	o_rst_n <= 1'b1;
end

endmodule

// ==== hdl/load_unit.sv ====
`timescale 1ns/100ps
`include "lsq_defines.svh"

module load_unit
	import lsq_pkg::*;
(
	input  logic               i_clk,
	input  logic               i_rst_n,
	// dispatch
	input  logic               i_insn_val,
	input  insn_t              i_insn,
	input  addr_t              i_base,
	// memory side
	input  logic               i_mem_ready,
	input  logic               i_resp_val,
	input  mem_resp_t          i_resp,
	input  logic               i_fwd_val,
	input  lq_idx_t            i_fwd_idx,
	output logic               o_stall,
	output logic               o_req_val,
	output mem_req_t           o_req,
	// writeback
	output logic               o_wb_val,
	output wb_t                o_wb,
	output logic [`DROP_W-1:0] o_drop_cnt
);

logic      we;
lq_entry_t entry;
lq_idx_t   tail;
logic      full;
logic      agu_val;
agu_job_t  agu_job;
logic      addr_wr_val;
addr_wr_t  addr_wr;
lq_entry_t head_entry;
logic      wkup_val;
mem_req_t  wkup;
logic      clr_wu;
logic      set_m;
logic      set_d;
lq_idx_t   resp_idx;
logic      re;

assign o_stall = full;

load_decode u_decode (
	.i_clk      (i_clk),
	.i_rst_n    (i_rst_n),
	.i_insn_val (i_insn_val),
	.i_insn     (i_insn),
	.i_base     (i_base),
	.i_tail     (tail),
	.i_full     (full),
	.o_we       (we),
	.o_entry    (entry),
	.o_agu_val  (agu_val),
	.o_agu_job  (agu_job),
	.o_drop_cnt (o_drop_cnt)
);

load_agu u_agu (
	.i_clk     (i_clk),
	.i_rst_n   (i_rst_n),
	.i_job_val (agu_val),
	.i_job     (agu_job),
	.o_wr_val  (addr_wr_val),
	.o_wr      (addr_wr)
);

// forward hints go straight to the S flags
load_addr_queue u_queue (
	.i_clk         (i_clk),
	.i_rst_n       (i_rst_n),
	.i_we          (we),
	.i_entry       (entry),
	.i_addr_wr_val (addr_wr_val),
	.i_addr_wr     (addr_wr),
	.i_set_s       (i_fwd_val),
	.i_s_idx       (i_fwd_idx),
	.i_set_m       (set_m),
	.i_m_idx       (resp_idx),
	.i_set_d       (set_d),
	.i_d_idx       (resp_idx),
	.i_clr_wu      (clr_wu),
	.i_re          (re),
	.o_head_entry  (head_entry),
	.o_tail        (tail),
	.o_empty       (),
	.o_full        (full),
	.o_wkup_val    (wkup_val),
	.o_wkup        (wkup)
);

load_issue_retire u_issue (
	.i_clk        (i_clk),
	.i_rst_n      (i_rst_n),
	.i_wkup_val   (wkup_val),
	.i_wkup       (wkup),
	.i_mem_ready  (i_mem_ready),
	.i_resp_val   (i_resp_val),
	.i_resp       (i_resp),
	.i_head_entry (head_entry),
	.o_clr_wu     (clr_wu),
	.o_req_val    (o_req_val),
	.o_req        (o_req),
	.o_set_m      (set_m),
	.o_set_d      (set_d),
	.o_resp_idx   (resp_idx),
	.o_re         (re),
	.o_wb_val     (o_wb_val),
	.o_wb         (o_wb)
);

endmodule

// ==== hdl/load_issue_retire.sv ====
`timescale 1ns/100ps

module load_issue_retire
	import lsq_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst_n,
	// wake-up from queue
	input  logic      i_wkup_val,
	input  mem_req_t  i_wkup,
	input  logic      i_mem_ready,
	// memory answer
	input  logic      i_resp_val,
	input  mem_resp_t i_resp,
	input  lq_entry_t i_head_entry,
	output logic      o_clr_wu,
	output logic      o_req_val,
	output mem_req_t  o_req,
	output logic      o_set_m,
	output logic      o_set_d,
	output lq_idx_t   o_resp_idx,
	output logic      o_re,
	output logic      o_wb_val,
	output wb_t       o_wb
);

// issue only when memory can take it
assign o_clr_wu = i_wkup_val & i_mem_ready;

// hit marks done, miss replays
assign o_set_m    = i_resp_val & i_resp.miss;
assign o_set_d    = i_resp_val & ~i_resp.miss;
assign o_resp_idx = i_resp.idx;

// in order retire from the head
assign o_re = i_head_entry.a & i_head_entry.d;

always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		o_req_val <= 1'b0;
		o_wb_val  <= 1'b0;
	end else begin
		o_req_val <= o_clr_wu;
		// no writeback for rd 0
		o_wb_val  <= o_re & i_head_entry.val;
	end
end

always_ff @(posedge i_clk) begin
	if (o_clr_wu)
		o_req <= i_wkup;
	if (o_re) begin
		o_wb.rd   <= i_head_entry.rd;
		o_wb.tag  <= i_head_entry.tag;
		o_wb.addr <= i_head_entry.addr;
	end
end

endmodule

// ==== hdl/load_addr_queue.sv ====
`timescale 1ns/100ps
`include "lsq_defines.svh"

module load_addr_queue
	import lsq_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst_n,
	// dispatch
	input  logic      i_we,
	input  lq_entry_t i_entry,
	// address from agu
	input  logic      i_addr_wr_val,
	input  addr_wr_t  i_addr_wr,
	// store forward hint
	input  logic      i_set_s,
	input  lq_idx_t   i_s_idx,
	// memory responses
	input  logic      i_set_m,
	input  lq_idx_t   i_m_idx,
	input  logic      i_set_d,
	input  lq_idx_t   i_d_idx,
	// issue and retire
	input  logic      i_clr_wu,
	input  logic      i_re,
	output lq_entry_t o_head_entry,
	output lq_idx_t   o_tail,
	output logic      o_empty,
	output logic      o_full,
	output logic      o_wkup_val,
	output mem_req_t  o_wkup
);

lq_idx_t head;
lq_idx_t tail;
lq_idx_t wu_idx;
logic    over;
logic    comp;
logic    wkup_found;

// control flags, one bit per cell
logic [`LQ_DEPTH-1:0] a_q;
logic [`LQ_DEPTH-1:0] v_q;
logic [`LQ_DEPTH-1:0] s_q;
logic [`LQ_DEPTH-1:0] m_q;
logic [`LQ_DEPTH-1:0] d_q;
logic [`LQ_DEPTH-1:0] rdy;

// payload
logic     val_q  [0:`LQ_DEPTH-1];
addr_t    addr_q [0:`LQ_DEPTH-1];
reg_idx_t rd_q   [0:`LQ_DEPTH-1];
tag_t     tag_q  [0:`LQ_DEPTH-1];

assign comp    = head == tail;
assign o_empty = comp & ~over;
assign o_full  = comp & over;
assign o_tail  = tail;

// ring pointers, over tells full from empty
always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		head <= '0;
		tail <= '0;
		over <= 1'b0;
	end else begin
		if (i_re)
			head <= head + 1'b1;
		if (i_we)
			tail <= tail + 1'b1;
		if (i_we && !i_re)
			over <= 1'b1;
		else if (i_re && !i_we)
			over <= 1'b0;
	end
end

// later updates override earlier ones on the same cell
always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		a_q <= '0;
		v_q <= '0;
		s_q <= '0;
		m_q <= '0;
		d_q <= '0;
	end else begin
		if (i_we) begin
			a_q[tail] <= i_entry.a;
			v_q[tail] <= i_entry.v;
			s_q[tail] <= 1'b0;
			m_q[tail] <= 1'b0;
			d_q[tail] <= 1'b0;
		end
		if (i_addr_wr_val)
			v_q[i_addr_wr.idx] <= 1'b1;
		if (i_set_s)
			s_q[i_s_idx] <= 1'b1;
		if (i_set_m)
			m_q[i_m_idx] <= 1'b1;
		// request sent, wait for the answer
		if (i_clr_wu) begin
			v_q[wu_idx] <= 1'b0;
			s_q[wu_idx] <= 1'b0;
			m_q[wu_idx] <= 1'b0;
		end
		if (i_set_d)
			d_q[i_d_idx] <= 1'b1;
		if (i_re)
			a_q[head] <= 1'b0;
	end
end

always_ff @(posedge i_clk) begin
	if (i_we) begin
		val_q[tail]  <= i_entry.val;
		addr_q[tail] <= i_entry.addr;
		rd_q[tail]   <= i_entry.rd;
		tag_q[tail]  <= i_entry.tag;
	end
	if (i_addr_wr_val)
		addr_q[i_addr_wr.idx] <= i_addr_wr.addr;
end

always_comb begin
	o_head_entry.a    = a_q[head];
	o_head_entry.val  = val_q[head];
	o_head_entry.addr = addr_q[head];
	o_head_entry.v    = v_q[head];
	o_head_entry.s    = s_q[head];
	o_head_entry.m    = m_q[head];
	o_head_entry.d    = d_q[head];
	o_head_entry.rd   = rd_q[head];
	o_head_entry.tag  = tag_q[head];
end

// ready to wake up and not yet done
assign rdy = a_q & (v_q | s_q | m_q) & ~d_q;

// lowest index wins, so scan downward
always_comb begin
	wkup_found = 1'b0;
	wu_idx     = '0;
	for (int k = `LQ_DEPTH - 1; k >= 0; k--) begin
		if (rdy[k]) begin
			wkup_found = 1'b1;
			wu_idx     = lq_idx_t'(k);
		end
	end
end

assign o_wkup_val  = wkup_found;
assign o_wkup.idx  = wu_idx;
assign o_wkup.addr = addr_q[wu_idx];

endmodule

// ==== hdl/load_agu.sv ====
`timescale 1ns/100ps
`include "lsq_defines.svh"

module load_agu
	import lsq_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  logic     i_job_val,
	input  agu_job_t i_job,
	output logic     o_wr_val,
	output addr_wr_t o_wr
);

addr_t imm_ext;

// sign extend the offset to address width
assign imm_ext = {{(`ADDR_W-`IMM_W){i_job.imm[`IMM_W-1]}}, i_job.imm};

always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		o_wr_val <= 1'b0;
	end else begin
		o_wr_val <= i_job_val;
	end
end

// address payload, one job per cycle
always_ff @(posedge i_clk) begin
	if (i_job_val) begin
		o_wr.idx  <= i_job.idx;
		o_wr.addr <= i_job.base + imm_ext;
	end
end

endmodule

// ==== hdl/load_decode.sv ====
`timescale 1ns/100ps
`include "lsq_defines.svh"

module load_decode
	import lsq_pkg::*;
(
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  logic              i_insn_val,
	input  insn_t             i_insn,
	input  addr_t             i_base,
	input  lq_idx_t           i_tail,
	input  logic              i_full,
	output logic              o_we,
	output lq_entry_t         o_entry,
	output logic              o_agu_val,
	output agu_job_t          o_agu_job,
	output logic [`DROP_W-1:0] o_drop_cnt
);

logic is_load;

assign is_load = i_insn.opc == `OPC_LOAD;

// accept only loads with room in the queue
assign o_we      = i_insn_val & is_load & ~i_full;
assign o_agu_val = o_we;

always_comb begin
	o_entry      = '0;
	o_entry.a    = 1'b1;
	// rd 0 retires silently
	o_entry.val  = |i_insn.rd;
	o_entry.rd   = i_insn.rd;
	o_entry.tag  = i_insn.tag;
end

always_comb begin
	o_agu_job.idx  = i_tail;
	o_agu_job.base = i_base;
	o_agu_job.imm  = i_insn.imm;
end

// count non-load opcodes
always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		o_drop_cnt <= '0;
	end else if (i_insn_val && !is_load) begin
		o_drop_cnt <= o_drop_cnt + 1'b1;
	end
end

endmodule

// ==== hdl/lsq_pkg.sv ====
`include "lsq_defines.svh"

package lsq_pkg;

	typedef logic [`LQ_DEPTH_LOG2-1:0] lq_idx_t;
	typedef logic [`ADDR_W-1:0]        addr_t;
	typedef logic [`REG_W-1:0]         reg_idx_t;
	typedef logic [`TAG_W-1:0]         tag_t;
	typedef logic [`IMM_W-1:0]         imm_t;

	// incoming instruction word
	typedef struct packed {
		logic [`OPC_W-1:0] opc;
		reg_idx_t          rd;
		tag_t              tag;
		imm_t              imm;
	} insn_t;

	// one load queue cell
	typedef struct packed {
		logic     a;
		logic     val;
		addr_t    addr;
		logic     v;
		logic     s;
		logic     m;
		logic     d;
		reg_idx_t rd;
		tag_t     tag;
	} lq_entry_t;

	typedef struct packed {
		lq_idx_t idx;
		addr_t   base;
		imm_t    imm;
	} agu_job_t;

	typedef struct packed {
		lq_idx_t idx;
		addr_t   addr;
	} addr_wr_t;

	typedef struct packed {
		lq_idx_t idx;
		addr_t   addr;
	} mem_req_t;

	// miss set means replay
	typedef struct packed {
		lq_idx_t idx;
		logic    miss;
	} mem_resp_t;

	typedef struct packed {
		reg_idx_t rd;
		tag_t     tag;
		addr_t    addr;
	} wb_t;

endpackage

// ==== hdl/lsq_defines.svh ====
`ifndef LSQ_DEFINES_SVH
`define LSQ_DEFINES_SVH

// load queue geometry
`define LQ_DEPTH_LOG2 4
`define LQ_DEPTH      16

// datapath widths
`define ADDR_W 32
`define REG_W  5
`define TAG_W  5
`define IMM_W  12
`define OPC_W  4

// dropped instruction counter width
`define DROP_W 16

// opcode of a load
`define OPC_LOAD 4'h3

`endif
